//--- logic/rvv_alu_pkg.sv
/*
  Shared widths, enums and micro-op structs for the vector ALU stage.
  The queue depth must stay a power of two because the pointers wrap freely.
  Operand data travel inside the micro-op; there is no register file read.
*/

package rvv_alu_pkg;

  // the control logic is written for exactly two issue slots
  localparam int NUM_ALU_UOP = 2;

  // operand and result slice of one vector register
  localparam int VLEN_SLICE = 64;

  // reservation station
  localparam int RS_DEPTH = 8;
  localparam int RS_PTR_W = $clog2(RS_DEPTH);
  localparam int RS_CNT_W = RS_PTR_W + 1;

  // tag that identifies the rob slot of a micro-op
  localparam int ROB_ENTRY_W = 4;

  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_minu = 3'd5,
    op_maxu = 3'd6,
    op_sll  = 3'd7
  } alu_op_e;

  // code 2'd3 is not named and falls back to 32-bit elements
  typedef enum logic [1:0] {
    sew_8  = 2'd0,
    sew_16 = 2'd1,
    sew_32 = 2'd2
  } sew_e;

  // one micro-op as it sits in the queue (137 bits)
  typedef struct packed {
    logic [ROB_ENTRY_W-1:0] rob_entry;
    alu_op_e                op;
    sew_e                   sew;
    logic [VLEN_SLICE-1:0]  vs2_data;
    logic [VLEN_SLICE-1:0]  vs1_data;
  } alu_uop_t;

  // one result going to the rob (68 bits)
  typedef struct packed {
    logic [ROB_ENTRY_W-1:0] rob_entry;
    logic [VLEN_SLICE-1:0]  vd_data;
  } alu_result_t;

endpackage

//--- logic/alu_rs_fifo.sv
/*
  In-order reservation station queue, one push and up to two pops per cycle.
  A push while full is dropped. Pops must never exceed the held entries;
  the issue control guarantees that through the slot valids.
*/

`timescale 1ns/1ps

module alu_rs_fifo
  import rvv_alu_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         push,
  input  alu_uop_t                     push_uop,
  input  logic     [NUM_ALU_UOP-1:0]   pop,
  output alu_uop_t [NUM_ALU_UOP-1:0]   head_uop,
  output logic                         rs_empty,
  output logic                         rs_1left,
  output logic                         rs_full
);

  alu_uop_t            mem [RS_DEPTH];

  logic [RS_PTR_W-1:0] wr_ptr;
  logic [RS_PTR_W-1:0] rd_ptr;
  logic [RS_PTR_W-1:0] rd_ptr_next;
  logic [RS_CNT_W-1:0] count;

  logic                do_push;
  logic [1:0]          pop_cnt;

  assign do_push = push && !rs_full;

  // pop[1] only ever comes with pop[0], so this is 0, 1 or 2
  assign pop_cnt = {1'b0, pop[0]} + {1'b0, pop[1]};

  // second oldest entry wraps with the pointer width
  assign rd_ptr_next = rd_ptr + RS_PTR_W'(1);

  // payload storage
  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_uop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + RS_PTR_W'(1);
      end
      rd_ptr <= rd_ptr + RS_PTR_W'(pop_cnt);
      count  <= count + RS_CNT_W'(do_push) - RS_CNT_W'(pop_cnt);
    end
  end

  // two oldest entries go straight to the ALU units
  assign head_uop[0] = mem[rd_ptr];
  assign head_uop[1] = mem[rd_ptr_next];

  // fill flags from the occupancy count
  assign rs_empty = (count == '0);
  assign rs_1left = (count == RS_CNT_W'(1));
  assign rs_full  = (count == RS_CNT_W'(RS_DEPTH));

endmodule

//--- logic/alu_issue_ctrl.sv
/*
  Slot valids and in-order pop control for the two ALU slots.
  Slot 1 retires only in a cycle where slot 0 retires as well.
*/

`timescale 1ns/1ps

module alu_issue_ctrl
  import rvv_alu_pkg::*;
(
  input  logic                   rs_empty,
  input  logic                   rs_1left,
  input  logic [NUM_ALU_UOP-1:0] result_valid,
  input  logic [NUM_ALU_UOP-1:0] result_ready,
  output logic [NUM_ALU_UOP-1:0] uop_valid,
  output logic [NUM_ALU_UOP-1:0] pop
);

  logic slot0_taken;
  logic slot1_taken;

  // slot 0 needs one entry, slot 1 needs at least two
  assign uop_valid[0] = !rs_empty;
  assign uop_valid[1] = !rs_empty && !rs_1left;

  // handshake per slot with the rob
  assign slot0_taken = result_valid[0] && result_ready[0];
  assign slot1_taken = result_valid[1] && result_ready[1];

  // slot 1 is chained onto slot 0 to keep retirement in order
  assign pop[0] = slot0_taken;
  assign pop[1] = slot0_taken && slot1_taken;

endmodule

//--- logic/alu_unit.sv
/*
  Combinational vector ALU for one 64-bit slice, 8, 16 or 32-bit elements.
  Add and subtract wrap per element, min and max compare unsigned.
  Shift left uses the low bits of the vs1 element, masked to the width.
  No masking or tail handling; every element is written.
*/

`timescale 1ns/1ps

module alu_unit
  import rvv_alu_pkg::*;
(
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  output logic        result_valid,
  output alu_result_t result
);

  logic [VLEN_SLICE-1:0] vs2;
  logic [VLEN_SLICE-1:0] vs1;

  // one candidate result per element width
  logic [VLEN_SLICE-1:0] res_e8;
  logic [VLEN_SLICE-1:0] res_e16;
  logic [VLEN_SLICE-1:0] res_e32;
  logic [VLEN_SLICE-1:0] vd;

  // single element op on zero-extended operands
  // mask keeps the element width
  // sh_mask limits the shift amount
  function automatic logic [31:0] elem_op(
    input alu_op_e     op,
    input logic [31:0] a,
    input logic [31:0] b,
    input logic [31:0] mask,
    input logic [4:0]  sh_mask
  );
    logic [4:0]  sh;
    logic [31:0] res;
    sh = b[4:0] & sh_mask;
    case (op)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_minu: res = (a < b) ? a : b;
      op_maxu: res = (a > b) ? a : b;
      op_sll:  res = a << sh;
      default: res = '0;
    endcase
    return res & mask;
  endfunction

  assign vs2 = uop.vs2_data;
  assign vs1 = uop.vs1_data;

  // eight byte lanes
  always_comb
  begin
    logic [31:0] tmp;
    tmp    = '0;
    res_e8 = '0;
    for (int i = 0; i < VLEN_SLICE / 8; i++)
    begin
      tmp = elem_op(uop.op,
                    {24'b0, vs2[i*8 +: 8]},
                    {24'b0, vs1[i*8 +: 8]},
                    32'h0000_00ff,
                    5'd7);
      res_e8[i*8 +: 8] = tmp[7:0];
    end
  end

  // four halfword lanes
  always_comb
  begin
    logic [31:0] tmp;
    tmp     = '0;
    res_e16 = '0;
    for (int i = 0; i < VLEN_SLICE / 16; i++)
    begin
      tmp = elem_op(uop.op,
                    {16'b0, vs2[i*16 +: 16]},
                    {16'b0, vs1[i*16 +: 16]},
                    32'h0000_ffff,
                    5'd15);
      res_e16[i*16 +: 16] = tmp[15:0];
    end
  end

  // two word lanes
  always_comb
  begin
    res_e32 = '0;
    for (int i = 0; i < VLEN_SLICE / 32; i++)
    begin
      res_e32[i*32 +: 32] = elem_op(uop.op,
                                    vs2[i*32 +: 32],
                                    vs1[i*32 +: 32],
                                    32'hffff_ffff,
                                    5'd31);
    end
  end

  // the unnamed sew code picks the 32-bit lanes
  always_comb
  begin
    case (uop.sew)
      sew_8:   vd = res_e8;
      sew_16:  vd = res_e16;
      default: vd = res_e32;
    endcase
  end

  // the result is ready in the same cycle the uop shows up
  assign result_valid     = uop_valid;
  assign result.rob_entry = uop.rob_entry;
  assign result.vd_data   = vd;

endmodule

//--- logic/rvv_alu.sv
/*
  Vector ALU execute stage: reservation station, issue control, two ALUs.
  Results go to the rob with one valid/ready pair per slot. Slot 1 counts
  as taken only when slot 0 is taken in the same cycle.
*/

`timescale 1ns/1ps

module rvv_alu
  import rvv_alu_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           push,
  input  alu_uop_t                       push_uop,
  output logic                           rs_full,
  output logic        [NUM_ALU_UOP-1:0]  result_valid,
  output alu_result_t [NUM_ALU_UOP-1:0]  result,
  input  logic        [NUM_ALU_UOP-1:0]  result_ready
);

  alu_uop_t [NUM_ALU_UOP-1:0] head_uop;
  logic                       rs_empty;
  logic                       rs_1left;
  logic     [NUM_ALU_UOP-1:0] uop_valid;
  logic     [NUM_ALU_UOP-1:0] pop;

  alu_rs_fifo u_rs_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .push_uop (push_uop),
    .pop      (pop),
    .head_uop (head_uop),
    .rs_empty (rs_empty),
    .rs_1left (rs_1left),
    .rs_full  (rs_full)
  );

  alu_issue_ctrl u_issue_ctrl (
    .rs_empty     (rs_empty),
    .rs_1left     (rs_1left),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .uop_valid    (uop_valid),
    .pop          (pop)
  );

  // one ALU per head slot
  for (genvar i = 0; i < NUM_ALU_UOP; i++)
  begin : g_alu_unit
    alu_unit u_alu_unit (
      .uop_valid    (uop_valid[i]),
      .uop          (head_uop[i]),
      .result_valid (result_valid[i]),
      .result       (result[i])
    );
  end

endmodule

//--- dv/rvv_alu_model.svh
/*
  Reference model for the vector ALU testbench and its LCG.
  Must be included inside a module that imports rvv_alu_pkg.
  The unnamed sew code is modelled as 32-bit elements.
*/

`ifndef RVV_ALU_MODEL_SVH
`define RVV_ALU_MODEL_SVH

localparam logic [31:0] LCG_SEED = 32'h862c;

// classic 32-bit LCG step
function automatic logic [31:0] lcg_step(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic int sew_bits(input sew_e sew);
  case (sew)
    sew_8:   return 8;
    sew_16:  return 16;
    default: return 32;
  endcase
endfunction

// one element with operands already cut to the element width
function automatic logic [63:0] model_elem(input alu_op_e op, input logic [63:0] a,
                                           input logic [63:0] b, input int ew);
  logic [63:0] mask;
  logic [63:0] r;
  mask = (64'h1 << ew) - 64'h1;
  case (op)
    op_add:  r = a + b;
    op_sub:  r = a - b;
    op_and:  r = a & b;
    op_or:   r = a | b;
    op_xor:  r = a ^ b;
    op_minu: r = (a <= b) ? a : b;
    op_maxu: r = (a >= b) ? a : b;
    op_sll:  r = a << (b & 64'(ew - 1));
    default: r = '0;
  endcase
  return r & mask;
endfunction

function automatic logic [63:0] model_vd(input alu_uop_t u);
  int          ew;
  logic [63:0] mask;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] vd;
  ew   = sew_bits(u.sew);
  mask = (64'h1 << ew) - 64'h1;
  vd   = '0;
  for (int e = 0; e < VLEN_SLICE / ew; e++)
  begin
    a  = (u.vs2_data >> (e * ew)) & mask;
    b  = (u.vs1_data >> (e * ew)) & mask;
    vd = vd | (model_elem(u.op, a, b, ew) << (e * ew));
  end
  return vd;
endfunction

`endif

//--- dv/rvv_alu_tb.sv
/*
  Testbench for the vector ALU stage with a queue based ROB model.
  Micro-ops and ready patterns come from an LCG with a fixed seed.
  Outputs are sampled a quarter period before the rising edge.
*/

`timescale 1ns/1ps

module rvv_alu_tb
  import rvv_alu_pkg::*;
();

  `include "rvv_alu_model.svh"

  localparam int CLK_PERIOD    = 20;
  localparam int RANDOM_CYCLES = 800;
  localparam int DRAIN_TIMEOUT = 200;

  logic                              clk;
  logic                              rst;
  logic                              push;
  alu_uop_t                          push_uop;
  logic                              rs_full;
  logic        [NUM_ALU_UOP-1:0]     result_valid;
  alu_result_t [NUM_ALU_UOP-1:0]     result;
  logic        [NUM_ALU_UOP-1:0]     result_ready;

  logic [31:0]                       lcg_state;
  logic [ROB_ENTRY_W-1:0]            next_rob;
  int                                stall_left;
  alu_uop_t                          exp_q[$];
  int                                mismatch_errs;
  int                                other_errs;
  int                                pushed_total;
  int                                taken_total;
  int                                dual_total;
  logic        [NUM_ALU_UOP-1:0]     cur_taken;
  logic        [NUM_ALU_UOP-1:0]     prev_valid;
  logic        [NUM_ALU_UOP-1:0]     prev_taken;
  alu_result_t [NUM_ALU_UOP-1:0]     prev_result;

  rvv_alu dut (
    .clk          (clk),
    .rst          (rst),
    .push         (push),
    .push_uop     (push_uop),
    .rs_full      (rs_full),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    lcg_state = lcg_step(lcg_state);
    return lcg_state;
  endfunction

  function automatic alu_uop_t random_uop();
    alu_uop_t    u;
    logic [31:0] ctl;
    ctl        = rand32();
    u.rob_entry = next_rob;
    u.op       = alu_op_e'(ctl[18:16]);
    u.sew      = sew_e'(ctl[21:20]);
    u.vs2_data = {rand32(), rand32()};
    u.vs1_data = {rand32(), rand32()};
    return u;
  endfunction

  task automatic drive_push(input logic want);
    if (want && !rs_full)
    begin
      push     = 1'b1;
      push_uop = random_uop();
      next_rob = next_rob + 4'd1;
    end
    else
    begin
      push = 1'b0;
    end
  endtask

  // mostly random readies with an occasional long stall on both slots
  task automatic drive_ready();
    logic [31:0] r;
    r = rand32();
    if (stall_left > 0)
    begin
      stall_left--;
      result_ready = '0;
    end
    else if (r[31:27] == 5'd0)
    begin
      stall_left   = 12 + int'(r[11:8]);
      result_ready = '0;
    end
    else
    begin
      result_ready = r[25:24];
    end
  endtask

  task automatic finish_run();
    $display("errors: mismatch %0d, other %0d", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic check_reset_outputs();
    assert (result_valid == '0) else
    begin
      mismatch_errs++;
      $display("mismatch result_valid in reset: got %h expected %h", result_valid, 2'b00);
    end
    assert (!rs_full) else
    begin
      mismatch_errs++;
      $display("mismatch rs_full in reset: got %h expected %h", rs_full, 1'b0);
    end
  endtask

  // flags against the model queue before this edge retires anything
  task automatic check_flags();
    assert (result_valid[0] == (exp_q.size() > 0)) else
    begin
      mismatch_errs++;
      $display("mismatch result_valid[0]: got %h expected %h",
               result_valid[0], exp_q.size() > 0);
    end
    assert (result_valid[1] == (exp_q.size() > 1)) else
    begin
      mismatch_errs++;
      $display("mismatch result_valid[1]: got %h expected %h",
               result_valid[1], exp_q.size() > 1);
    end
    assert (rs_full == (exp_q.size() == RS_DEPTH)) else
    begin
      mismatch_errs++;
      $display("mismatch rs_full: got %h expected %h", rs_full, exp_q.size() == RS_DEPTH);
    end
  endtask

  // a result not taken last cycle must still be there or have moved up to slot 0
  task automatic check_hold();
    if (prev_valid[0] && !prev_taken[0])
      assert (result_valid[0] && result[0] == prev_result[0]) else
      begin
        mismatch_errs++;
        $display("mismatch result[0] while held: got %h expected %h", result[0], prev_result[0]);
      end
    if (prev_valid[1] && !prev_taken[1] && prev_taken[0])
      assert (result[0] == prev_result[1]) else
      begin
        mismatch_errs++;
        $display("mismatch result[0] after move: got %h expected %h", result[0], prev_result[1]);
      end
    if (prev_valid[1] && !prev_taken[1] && !prev_taken[0])
      assert (result[1] == prev_result[1]) else
      begin
        mismatch_errs++;
        $display("mismatch result[1] while held: got %h expected %h", result[1], prev_result[1]);
      end
  endtask

  task automatic check_take(input int slot);
    alu_uop_t              want;
    logic [VLEN_SLICE-1:0] want_vd;
    assert (exp_q.size() > 0) else
    begin
      other_errs++;
      $display("slot %0d result taken with no outstanding micro-op", slot);
    end
    if (exp_q.size() > 0)
    begin
      want    = exp_q.pop_front();
      want_vd = model_vd(want);
      taken_total++;
      assert (result[slot].rob_entry == want.rob_entry) else
      begin
        mismatch_errs++;
        $display("mismatch result[%0d].rob_entry: got %h expected %h",
                 slot, result[slot].rob_entry, want.rob_entry);
      end
      assert (result[slot].vd_data == want_vd) else
      begin
        mismatch_errs++;
        $display("mismatch result[%0d].vd_data: got %h expected %h (op %0d sew %0d)",
                 slot, result[slot].vd_data, want_vd, want.op, want.sew);
      end
    end
  endtask

  task automatic wait_drain(input int limit, output bit drained);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
    end
    drained = (exp_q.size() == 0);
    if (!drained)
    begin
      other_errs++;
      $display("timeout: %0d micro-ops still queued after %0d cycles", exp_q.size(), limit);
    end
  endtask

  // ROB model samples once per cycle while inputs are stable
  initial
  begin
    prev_valid  = '0;
    prev_taken  = '0;
    prev_result = '0;
    forever
    begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      if (rst)
      begin
        prev_valid = '0;
        prev_taken = '0;
      end
      else
      begin
        cur_taken[0] = result_valid[0] && result_ready[0];
        cur_taken[1] = cur_taken[0] && result_valid[1] && result_ready[1];
        check_flags();
        check_hold();
        if (cur_taken[0])
          check_take(0);
        if (cur_taken[1])
        begin
          check_take(1);
          dual_total++;
        end
        if (push && !rs_full)
        begin
          exp_q.push_back(push_uop);
          pushed_total++;
        end
        prev_valid  = result_valid;
        prev_taken  = cur_taken;
        prev_result = result;
      end
    end
  end

  initial
  begin
    bit          drained;
    logic [31:0] r;
    rst           = 1'b1;
    push          = 1'b0;
    push_uop      = '0;
    result_ready  = '0;
    lcg_state     = LCG_SEED;
    next_rob      = '0;
    stall_left    = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    pushed_total  = 0;
    taken_total   = 0;
    dual_total    = 0;

    for (int i = 0; i < 5; i++)
    begin
      @(negedge clk);
      check_reset_outputs();
    end
    rst = 1'b0;

    // random traffic with stalls
    for (int i = 0; i < RANDOM_CYCLES; i++)
    begin
      @(negedge clk);
      r = rand32();
      drive_push(r[30:29] != 2'b00);
      drive_ready();
    end
    @(negedge clk);
    push         = 1'b0;
    result_ready = 2'b11;
    wait_drain(DRAIN_TIMEOUT, drained);

    // fill the queue with the rob stalled
    if (drained)
    begin
      @(negedge clk);
      result_ready = '0;
      for (int i = 0; i < RS_DEPTH; i++)
      begin
        assert (!rs_full) else
        begin
          other_errs++;
          $display("rs_full went high after only %0d pushes", i);
        end
        drive_push(1'b1);
        @(negedge clk);
      end
      push = 1'b0;
      assert (rs_full) else
      begin
        other_errs++;
        $display("rs_full still low after %0d pushes", RS_DEPTH);
      end
      repeat (10) @(negedge clk);
      assert (rs_full && result_valid == '1) else
      begin
        other_errs++;
        $display("queue gave up entries while result_ready was low");
      end
      result_ready = 2'b11;
      wait_drain(DRAIN_TIMEOUT, drained);
    end

    if (drained)
    begin
      assert (pushed_total == taken_total) else
      begin
        other_errs++;
        $display("pushed %0d micro-ops but %0d were retired", pushed_total, taken_total);
      end
      assert (dual_total > 0) else
      begin
        other_errs++;
        $display("no cycle retired both slots");
      end
    end
    finish_run();
  end

endmodule

//--- project.f
+incdir+dv
logic/rvv_alu_pkg.sv
logic/alu_rs_fifo.sv
logic/alu_issue_ctrl.sv
logic/alu_unit.sv
logic/rvv_alu.sv
dv/rvv_alu_tb.sv

//--- Makefile
# Verilator build and run for the vector ALU execute stage

VERILATOR ?= verilator
TOP       ?= rvv_alu_tb
FILE_LIST ?= project.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
FAIL_MSG  ?= STATUS: FAIL
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST)) dv/rvv_alu_model.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
